// ==== rtl/coalesce_pkg.sv ====
//**************************************
// Widths, derived types and lane count
// shared by the coalescer RTL and its
// testbench
//**************************************

`default_nettype none

package coalesce_pkg;

    // Byte address width
    localparam int unsigned ADDR_W = 32;
    // Lanes in one warp
    localparam int unsigned NUM_LANES = 8;
    // Byte offset bits inside a 64 byte block
    localparam int unsigned BLOCK_IDX_W = 6;
    // Data width returned to each lane
    localparam int unsigned WORD_W = 32;
    // Words carried by one memory block
    localparam int unsigned WORDS_PER_BLOCK = 16;
    // Word index bits inside a block
    localparam int unsigned WORD_IDX_W = 4;
    // Address bits left once the block offset is dropped
    localparam int unsigned BLOCK_ADDR_W = ADDR_W - BLOCK_IDX_W;

    // Full byte address of one lane
    typedef logic [ADDR_W-1:0] addr_t;
    // Block address, as sent to memory
    typedef logic [BLOCK_ADDR_W-1:0] block_addr_t;
    // Byte offset of a lane inside its block
    typedef logic [BLOCK_IDX_W-1:0] block_idx_t;
    // One bit per lane
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    // Datum of one lane
    typedef logic [WORD_W-1:0] word_t;
    // Whole block, word k at bits 32k upward
    typedef logic [WORDS_PER_BLOCK*WORD_W-1:0] block_data_t;

endpackage : coalesce_pkg

`default_nettype wire

// ==== rtl/coalesce_comparator.sv ====
//**************************************
// Coalesce comparator: first pending
// block, its member lanes and the block
// offset of every lane
//**************************************

`timescale 1ns/1ps
`default_nettype none

module coalesce_comparator (
    // Lanes still waiting for data
    input  wire coalesce_pkg::lane_mask_t                            valid_i,
    // Latched byte address of every lane
    input  wire coalesce_pkg::addr_t [coalesce_pkg::NUM_LANES-1:0]   addr_i,
    // Block of the lowest pending lane
    output coalesce_pkg::block_addr_t                                coalesced_addr_o,
    // Pending lanes that fall in that block
    output coalesce_pkg::lane_mask_t                                 members_o,
    // Low address bits of each lane
    output coalesce_pkg::block_idx_t [coalesce_pkg::NUM_LANES-1:0]   member_block_offsets_o
);
    import coalesce_pkg::*;

    // Set once the lowest pending lane has been seen
    logic first_seen;

    // Priority scan from lane 0 upward
    always_comb begin : pick_first_block
        coalesced_addr_o = '0;
        first_seen       = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (valid_i[i] && !first_seen) begin
                // Strip the byte offset to get the block address
                coalesced_addr_o = addr_i[i][ADDR_W-1:BLOCK_IDX_W];
                first_seen       = 1'b1;
            end
        end
    end : pick_first_block

    // Every pending lane with the same block address joins this round
    always_comb begin : mark_members
        members_o = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (valid_i[i] && (addr_i[i][ADDR_W-1:BLOCK_IDX_W] == coalesced_addr_o)) begin
                members_o[i] = 1'b1;
            end
        end
    end : mark_members

    // Offset inside the block, used later for word selection
    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_offsets
        assign member_block_offsets_o[i] = addr_i[i][BLOCK_IDX_W-1:0];
    end : gen_offsets

endmodule : coalesce_comparator

`default_nettype wire

// ==== rtl/coalesce_sequencer.sv ====
//**************************************
// Coalesce sequencer: warp latch,
// pending mask and the IDLE / ISSUE /
// WAIT round FSM
//**************************************

`timescale 1ns/1ps
`default_nettype none

module coalesce_sequencer (
    input  wire                                                      clk_i,
    input  wire                                                      rst_n_i,
    // Warp start strobe and the warp itself
    input  wire                                                      start_i,
    input  wire coalesce_pkg::lane_mask_t                            lane_valid_i,
    input  wire coalesce_pkg::addr_t [coalesce_pkg::NUM_LANES-1:0]   lane_addr_i,
    // End of a block read
    input  wire                                                      mem_rsp_valid_i,
    // Comparator results for the current pending set
    input  wire coalesce_pkg::block_addr_t                           first_block_i,
    input  wire coalesce_pkg::lane_mask_t                            member_mask_i,
    // Pending lanes and addresses towards the comparator
    output coalesce_pkg::lane_mask_t                                 pending_o,
    output coalesce_pkg::addr_t [coalesce_pkg::NUM_LANES-1:0]        lane_addr_o,
    // Block read request
    output logic                                                     mem_req_valid_o,
    output coalesce_pkg::block_addr_t                                mem_req_addr_o,
    // Extractor controls
    output logic                                                     fill_en_o,
    output coalesce_pkg::lane_mask_t                                 fill_mask_o,
    output logic                                                     clear_en_o,
    // Status
    output logic                                                     busy_o,
    output logic                                                     done_o
);
    import coalesce_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } state_t;

    state_t                state_q;
    // Lanes not yet served in this warp
    lane_mask_t            pending_q;
    // Addresses captured at start
    addr_t [NUM_LANES-1:0] lane_addr_q;

    logic       start_accept;
    logic       rsp_accept;
    // Pending set once the current members are served
    lane_mask_t pending_left;

    // Start only counts while idle
    assign start_accept = start_i && (state_q == IDLE);
    // Responses outside WAIT are dropped
    assign rsp_accept   = mem_rsp_valid_i && (state_q == WAIT);
    assign pending_left = pending_q & ~fill_mask_o;

    // Extractor clears on an accepted start and fills on the response
    assign clear_en_o  = start_accept;
    assign fill_en_o   = rsp_accept;
    assign pending_o   = pending_q;
    assign lane_addr_o = lane_addr_q;

    // Round FSM
    // ISSUE either sends the next block read or finishes the warp
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q         <= IDLE;
            pending_q       <= '0;
            fill_mask_o     <= '0;
            mem_req_valid_o <= 1'b0;
            busy_o          <= 1'b0;
            done_o          <= 1'b0;
        end else begin
            // Request and done are single cycle strobes
            mem_req_valid_o <= 1'b0;
            done_o          <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_accept) begin
                        pending_q <= lane_valid_i;
                        state_q   <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (pending_q != '0) begin
                        // Remember who is served by this block
                        mem_req_valid_o <= 1'b1;
                        fill_mask_o     <= member_mask_i;
                        busy_o          <= 1'b1;
                        state_q         <= WAIT;
                    end else begin
                        // Nothing left, also covers an empty warp
                        done_o  <= 1'b1;
                        busy_o  <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                WAIT: begin
                    if (rsp_accept) begin
                        pending_q <= pending_left;
                        state_q   <= ISSUE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Warp addresses, captured with the start strobe
    always_ff @(posedge clk_i) begin
        if (start_accept) begin
            lane_addr_q <= lane_addr_i;
        end
    end

    // Block address of the read, valid with mem_req_valid_o
    always_ff @(posedge clk_i) begin
        if ((state_q == ISSUE) && (pending_q != '0)) begin
            mem_req_addr_o <= first_block_i;
        end
    end

endmodule : coalesce_sequencer

`default_nettype wire

// ==== rtl/lane_word_extractor.sv ====
//**************************************
// Lane word extractor: one result word
// per lane, filled from returned blocks
//**************************************

`timescale 1ns/1ps
`default_nettype none

module lane_word_extractor (
    input  wire                                                      clk_i,
    input  wire                                                      rst_n_i,
    // Wipe all results at warp start
    input  wire                                                      clear_en_i,
    // Block data is on block_data_i this cycle
    input  wire                                                      fill_en_i,
    // Lanes served by this block
    input  wire coalesce_pkg::lane_mask_t                            fill_mask_i,
    // Byte offset of every lane inside its block
    input  wire coalesce_pkg::block_idx_t [coalesce_pkg::NUM_LANES-1:0] block_offsets_i,
    // Returned block
    input  wire coalesce_pkg::block_data_t                           block_data_i,
    // Result word of every lane
    output coalesce_pkg::word_t [coalesce_pkg::NUM_LANES-1:0]        lane_data_o
);
    import coalesce_pkg::*;

    // Block split into its words, word k at bits 32k upward
    word_t [WORDS_PER_BLOCK-1:0]     block_words;
    // Word index picked by each lane
    logic [NUM_LANES-1:0][WORD_IDX_W-1:0] word_sel;

    assign block_words = block_data_i;

    // Upper offset bits select the word
    // the two byte bits below them are ignored
    always_comb begin : select_words
        for (int i = 0; i < NUM_LANES; i++) begin
            word_sel[i] = block_offsets_i[i][BLOCK_IDX_W-1 -: WORD_IDX_W];
        end
    end : select_words

    // Result registers
    // Clear has priority, so a new warp never sees old words
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lane_data_o <= '0;
        end else if (clear_en_i) begin
            lane_data_o <= '0;
        end else if (fill_en_i) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                // Only member lanes take a word from this block
                if (fill_mask_i[i]) begin
                    lane_data_o[i] <= block_words[word_sel[i]];
                end
            end
        end
    end

endmodule : lane_word_extractor

`default_nettype wire

// ==== rtl/coalescer_top.sv ====
//**************************************
// Coalescer top: sequencer, comparator
// and word extractor wired together
//**************************************

`timescale 1ns/1ps
`default_nettype none

module coalescer_top (
    input  wire                                                      clk_i,
    input  wire                                                      rst_n_i,
    // Warp issue
    input  wire                                                      start_i,
    input  wire coalesce_pkg::lane_mask_t                            lane_valid_i,
    input  wire coalesce_pkg::addr_t [coalesce_pkg::NUM_LANES-1:0]   lane_addr_i,
    output wire                                                      busy_o,
    // Block read towards memory
    output wire                                                      mem_req_valid_o,
    output wire coalesce_pkg::block_addr_t                           mem_req_addr_o,
    // Block return from memory
    input  wire                                                      mem_rsp_valid_i,
    input  wire coalesce_pkg::block_data_t                           mem_rsp_data_i,
    // Warp completion and per lane results
    output wire                                                      done_o,
    output wire coalesce_pkg::word_t [coalesce_pkg::NUM_LANES-1:0]   lane_data_o
);
    import coalesce_pkg::*;

    // Sequencer to comparator
    lane_mask_t                 pending_mask;
    addr_t [NUM_LANES-1:0]      lane_addr;
    // Comparator back to sequencer
    block_addr_t                first_block;
    lane_mask_t                 member_mask;
    // Comparator to extractor
    block_idx_t [NUM_LANES-1:0] block_offsets;
    // Sequencer to extractor
    logic                       fill_en;
    lane_mask_t                 fill_mask;
    logic                       clear_en;

    coalesce_sequencer coalesce_sequencer_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .start_i         (start_i),
        .lane_valid_i    (lane_valid_i),
        .lane_addr_i     (lane_addr_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .first_block_i   (first_block),
        .member_mask_i   (member_mask),
        .pending_o       (pending_mask),
        .lane_addr_o     (lane_addr),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .fill_en_o       (fill_en),
        .fill_mask_o     (fill_mask),
        .clear_en_o      (clear_en),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    // Purely combinational, sees the pending set every cycle
    coalesce_comparator coalesce_comparator_i (
        .valid_i                (pending_mask),
        .addr_i                 (lane_addr),
        .coalesced_addr_o       (first_block),
        .members_o              (member_mask),
        .member_block_offsets_o (block_offsets)
    );

    // Response data goes straight into the extractor
    lane_word_extractor lane_word_extractor_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .clear_en_i      (clear_en),
        .fill_en_i       (fill_en),
        .fill_mask_i     (fill_mask),
        .block_offsets_i (block_offsets),
        .block_data_i    (mem_rsp_data_i),
        .lane_data_o     (lane_data_o)
    );

endmodule : coalescer_top

`default_nettype wire

// ==== testbench/coalescer_checker.sv ====
//****************************************
// Strobe protocol assertions, bound to
// the coalescer top level
//****************************************

`timescale 1ns/1ps
`default_nettype none

module coalescer_checker (
    input wire clk_i,
    input wire rst_n_i,
    input wire busy_i,
    input wire mem_req_valid_i,
    input wire mem_rsp_valid_i,
    input wire done_i
);
    // A block read is in flight
    logic rsp_pending;
    int   done_fails;
    int   req_fails;
    int   busy_fails;
    int   overlap_fails;
    // Sum of all failed assertions
    int   failure_count;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_pending <= 1'b0;
        end else if (mem_rsp_valid_i) begin
            rsp_pending <= 1'b0;
        end else if (mem_req_valid_i) begin
            rsp_pending <= 1'b1;
        end
    end

    always_comb failure_count = done_fails + req_fails + busy_fails + overlap_fails;

    done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> !done_i)
        else begin
            $error("done_o stayed high for more than one cycle");
            done_fails++;
        end

    req_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                 mem_req_valid_i |=> !mem_req_valid_i)
        else begin
            $error("mem_req_valid_o stayed high for more than one cycle");
            req_fails++;
        end

    req_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                     mem_req_valid_i |-> busy_i)
        else begin
            $error("mem_req_valid_o pulsed while busy_o was low");
            busy_fails++;
        end

    // One outstanding block read at most
    req_after_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                    mem_req_valid_i |-> !rsp_pending)
        else begin
            $error("Request issued before the previous response");
            overlap_fails++;
        end

endmodule : coalescer_checker

bind coalescer_top coalescer_checker coalescer_checker_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .busy_i          (busy_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .done_i          (done_o)
);

`default_nettype wire

// ==== testbench/coalescer_monitor.sv ====
//****************************************
// Coalescer monitor: predicts requests and
// lane data per warp, compares, reports
//****************************************

`timescale 1ns/1ps
`default_nettype none

module coalescer_monitor (
    input  wire                                                    clk_i,
    input  wire                                                    rst_n_i,
    input  wire                                                    start_i,
    input  wire                                                    busy_i,
    input  wire coalesce_pkg::lane_mask_t                          lane_valid_i,
    input  wire coalesce_pkg::addr_t [coalesce_pkg::NUM_LANES-1:0] lane_addr_i,
    input  wire                                                    mem_req_valid_i,
    input  wire coalesce_pkg::block_addr_t                         mem_req_addr_i,
    input  wire                                                    mem_rsp_valid_i,
    input  wire                                                    done_i,
    input  wire coalesce_pkg::word_t [coalesce_pkg::NUM_LANES-1:0] lane_data_i,
    input  wire [127:0]                                            test_name_i,
    input  var int                                                 exp_reqs_i,
    output int                                                     test_count_o,
    output int                                                     error_count_o
);
    import coalesce_pkg::*;

    // Distinct blocks in first-appearance order
    block_addr_t           exp_blocks [$];
    word_t [NUM_LANES-1:0] exp_data;
    logic [127:0]          name_q;
    int                    exp_reqs_q;
    int                    req_count;
    int                    test_errors;
    // Edges since start or the last response
    int                    edges_since;
    bit                    in_warp;
    bit                    reset_check;

    task automatic predict_warp(input lane_mask_t valid, input addr_t [NUM_LANES-1:0] addr);
        block_addr_t blk;
        bit          found;
        exp_blocks.delete();
        for (int i = 0; i < NUM_LANES; i++) begin
            exp_data[i] = '0;
            if (valid[i]) begin
                blk   = addr[i][ADDR_W-1:BLOCK_IDX_W];
                found = 1'b0;
                foreach (exp_blocks[j]) begin
                    if (exp_blocks[j] == blk) begin
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    exp_blocks.push_back(blk);
                end
                // Memory word k of block b holds ~(b*16 + k)
                exp_data[i] = ~(32'(blk) * 32'd16 + 32'(addr[i][BLOCK_IDX_W-1 -: WORD_IDX_W]));
            end
        end
    endtask

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("CHECK FAILED test %0s %0s expected %h actual %h", name_q, what, expected, actual);
        test_errors++;
    endtask

    task automatic check_request();
        if (req_count >= exp_blocks.size()) begin
            $display("Test %0s issued an extra request for block %h", name_q, mem_req_addr_i);
            test_errors++;
        end else if (mem_req_addr_i != exp_blocks[req_count]) begin
            report_value($sformatf("request %0d block", req_count),
                         32'(exp_blocks[req_count]), 32'(mem_req_addr_i));
        end
        if (edges_since != 2) begin
            $display("Test %0s request %0d was not one cycle after start or response",
                     name_q, req_count);
            test_errors++;
        end
        req_count++;
    endtask

    task automatic finish_warp();
        if (edges_since != 2) begin
            $display("Test %0s done was not one cycle after the last event", name_q);
            test_errors++;
        end
        if (busy_i) begin
            $display("Test %0s busy_o did not fall with done_o", name_q);
            test_errors++;
        end
        if (req_count < exp_blocks.size()) begin
            $display("Test %0s is missing requests, %0d issued of %0d",
                     name_q, req_count, exp_blocks.size());
            test_errors++;
        end
        if ((exp_reqs_q >= 0) && (req_count != exp_reqs_q)) begin
            report_value("request count", 32'(exp_reqs_q), 32'(req_count));
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_data_i[i] != exp_data[i]) begin
                report_value($sformatf("lane %0d data", i), exp_data[i], lane_data_i[i]);
            end
        end
        $display("Test %0s finished with %0d requests, %0s", name_q, req_count,
                 (test_errors == 0) ? "ok" : "with errors");
        test_count_o++;
        error_count_o += test_errors;
        in_warp = 1'b0;
    endtask

    // DUT outputs are settled at the rising edge
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_warp     = 1'b0;
            reset_check = 1'b1;
        end else begin
            edges_since++;
            if (reset_check && (lane_data_i != '0)) begin
                $display("Lane data was not zero after reset");
                error_count_o++;
            end
            reset_check = 1'b0;
            if (!in_warp) begin
                if (busy_i || mem_req_valid_i || done_i) begin
                    $display("DUT active between warps: busy %b request %b done %b",
                             busy_i, mem_req_valid_i, done_i);
                    error_count_o++;
                end
                if (start_i) begin
                    predict_warp(lane_valid_i, lane_addr_i);
                    name_q      = test_name_i;
                    exp_reqs_q  = exp_reqs_i;
                    req_count   = 0;
                    test_errors = 0;
                    edges_since = 0;
                    in_warp     = 1'b1;
                end
            end else begin
                if (mem_req_valid_i) begin
                    check_request();
                end
                // Busy holds from the first request until done
                if ((req_count > 0) && !done_i && !busy_i) begin
                    $display("Test %0s busy_o dropped before done_o", name_q);
                    test_errors++;
                end
                if (mem_rsp_valid_i) begin
                    edges_since = 0;
                end
                if (done_i) begin
                    finish_warp();
                end
            end
        end
    end

endmodule : coalescer_monitor

`default_nettype wire

// ==== testbench/tb_coalescer.sv ====
//****************************************
// Coalescer testbench: clock, reset, test
// table, random warps, block memory model,
// watchdog and closing result
//****************************************

`timescale 1ns/1ps
`default_nettype none

module tb_coalescer;
    import coalesce_pkg::*;

    localparam int NUM_DIRECTED  = 5;
    localparam int NUM_RANDOM    = 40;
    localparam int NUM_TESTS     = NUM_DIRECTED + NUM_RANDOM;
    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 16;
    // 8 requests of at most 8 cycles per test, plus reset
    localparam int WATCHDOG_NS   = NUM_TESTS * 8 * 8 * CLK_PERIOD_NS
                                   + RESET_CYCLES * CLK_PERIOD_NS;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  start;
    lane_mask_t            lane_valid;
    addr_t [NUM_LANES-1:0] lane_addr;
    logic                  busy;
    logic                  mem_req_valid;
    block_addr_t           mem_req_addr;
    logic                  mem_rsp_valid;
    block_data_t           mem_rsp_data;
    logic                  done;
    word_t [NUM_LANES-1:0] lane_data;
    // Tag of the running warp, seen by the monitor at start
    logic [127:0]          test_name;
    int                    exp_reqs;
    int                    test_count;
    int                    error_count;
    int                    total_errors;

    // Test table, a request count of -1 means the count is not listed
    logic [127:0]          tab_name  [NUM_TESTS];
    lane_mask_t            tab_valid [NUM_TESTS];
    addr_t [NUM_LANES-1:0] tab_addr  [NUM_TESTS];
    int                    tab_reqs  [NUM_TESTS];

    logic [31:0] rng_state = 32'd57581;

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    coalescer_top coalescer_top_i (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .start_i         (start),
        .lane_valid_i    (lane_valid),
        .lane_addr_i     (lane_addr),
        .busy_o          (busy),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_addr_o  (mem_req_addr),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_data_i  (mem_rsp_data),
        .done_o          (done),
        .lane_data_o     (lane_data)
    );

    coalescer_monitor coalescer_monitor_i (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .start_i         (start),
        .busy_i          (busy),
        .lane_valid_i    (lane_valid),
        .lane_addr_i     (lane_addr),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_addr_i  (mem_req_addr),
        .mem_rsp_valid_i (mem_rsp_valid),
        .done_i          (done),
        .lane_data_i     (lane_data),
        .test_name_i     (test_name),
        .exp_reqs_i      (exp_reqs),
        .test_count_o    (test_count),
        .error_count_o   (error_count)
    );

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Word k of a block holds its inverted word address
    function automatic block_data_t block_contents(input block_addr_t blk);
        block_data_t data;
        word_t       word_addr;
        for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
            word_addr = 32'(blk) * 32'd16 + 32'(k);
            data[k*WORD_W +: WORD_W] = ~word_addr;
        end
        return data;
    endfunction

    task automatic add_entry(input int idx, input logic [127:0] name, input lane_mask_t valid,
                             input int reqs, input addr_t [NUM_LANES-1:0] addr);
        tab_name[idx]  = name;
        tab_valid[idx] = valid;
        tab_reqs[idx]  = reqs;
        tab_addr[idx]  = addr;
    endtask

    // Lanes draw from four base blocks so that several share one
    task automatic add_random(input int idx);
        addr_t                 base [4];
        addr_t [NUM_LANES-1:0] addr;
        logic [31:0]           r;
        logic [127:0]          name;
        for (int b = 0; b < 4; b++) begin
            base[b] = next_random() & 32'hFFFF_FFC0;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            r       = next_random();
            addr[i] = base[r[1:0]] | {26'b0, r[7:4], 2'b00};
        end
        r = next_random();
        $sformat(name, "random_%0d", idx - NUM_DIRECTED);
        add_entry(idx, name, r[15:8], -1, addr);
    endtask

    // Answers each block read after 1 to 4 cycles
    initial begin : memory_model
        block_addr_t blk;
        int          latency;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever begin
            @(posedge clk);
            if (rst_n && mem_req_valid) begin
                blk     = mem_req_addr;
                latency = 1 + int'(next_random() % 32'd4);
                repeat (latency - 1) @(posedge clk);
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= block_contents(blk);
                @(posedge clk);
                mem_rsp_valid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, warps stopped completing", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        rst_n      = 1'b0;
        start      = 1'b0;
        lane_valid = '0;
        lane_addr  = '0;
        test_name  = '0;
        exp_reqs   = -1;
        // Addresses listed from lane 7 down to lane 0
        add_entry(0, "one_block", 8'hFF, 1,
                  {32'h0000_1014, 32'h0000_1020, 32'h0000_1030, 32'h0000_1004,
                   32'h0000_103C, 32'h0000_101C, 32'h0000_1000, 32'h0000_100C});
        add_entry(1, "eight_blocks", 8'hFF, 8,
                  {32'h0000_0000, 32'h1234_5678, 32'h0000_7F88, 32'hFFFF_FFC0,
                   32'h0000_0040, 32'h0001_000C, 32'h0000_7F44, 32'h0000_8000});
        // Lanes 0 3 5 in block A, 1 6 in block B, lanes 3 and 5 identical
        add_entry(2, "interleaved", 8'h6B, 2,
                  {32'h0000_0000, 32'h0000_803C, 32'h0000_207C, 32'h0000_2040,
                   32'h0000_207C, 32'hDEAD_BEEC, 32'h0000_8010, 32'h0000_2048});
        add_entry(3, "empty_mask", 8'h00, 0, {NUM_LANES{32'h0000_2040}});
        add_entry(4, "last_lane", 8'h80, 1, {32'h0000_0FFC, {7{32'h0000_1000}}});
        for (int t = NUM_DIRECTED; t < NUM_TESTS; t++) begin
            add_random(t);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        for (int t = 0; t < NUM_TESTS; t++) begin
            start      <= 1'b1;
            lane_valid <= tab_valid[t];
            lane_addr  <= tab_addr[t];
            test_name  <= tab_name[t];
            exp_reqs   <= tab_reqs[t];
            @(posedge clk);
            // Inputs change after start, the DUT must work from its latch
            start      <= 1'b0;
            lane_valid <= ~tab_valid[t];
            lane_addr  <= ~tab_addr[t];
            @(posedge clk);
            while (done !== 1'b1) begin
                @(posedge clk);
            end
        end
        repeat (4) @(posedge clk);

        total_errors = error_count + coalescer_top_i.coalescer_checker_i.failure_count;
        if (test_count != NUM_TESTS) begin
            $display("Only %0d of %0d tests reached done", test_count, NUM_TESTS);
        end
        $display("Tests run %0d of %0d, errors %0d", test_count, NUM_TESTS, total_errors);
        if ((total_errors == 0) && (test_count == NUM_TESTS)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_coalescer

`default_nettype wire

// ==== tb.f ====
rtl/coalesce_pkg.sv
rtl/coalesce_comparator.sv
rtl/coalesce_sequencer.sv
rtl/lane_word_extractor.sv
rtl/coalescer_top.sv
testbench/coalescer_checker.sv
testbench/coalescer_monitor.sv
testbench/tb_coalescer.sv

// ==== Makefile ====
TOP := tb_coalescer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+100 2>&1 | tee sim.log
	@if grep -q "Testbench failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Testbench passed" sim.log || (echo "Simulation ended without a result"; exit 1)
	@echo "Simulation PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log
